/* csr_unit.f */
hdl/csr_pkg.sv
hdl/csr_access_if.sv
hdl/csr_request_ctrl.sv
hdl/csr_trap_regs.sv
hdl/csr_config_regs.sv
hdl/csr_unit.sv
+incdir+testbench
testbench/tb_csr_unit.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f csr_unit.f --top-module tb_csr_unit -o tb_csr_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/tb_csr_unit)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "test passed" <<< "$sim_output"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* testbench/csr_tests.svh */
// CSR unit directed tests

// MXL=1 for RV32 plus the I and S extension bits
localparam csr_pkg::word_t misa_rv32is = 32'h4000_0000 | (32'd1 << 8) | (32'd1 << 18);

task automatic reset_values();
    csr_pkg::word_t data;
    check_priv("priv", priv, csr_pkg::priv_machine);
    csr_read(csr_pkg::csr_mstatus, data);
    check_word("mstatus", data, '0);
    csr_read(csr_pkg::csr_misa, data);
    check_word("misa", data, misa_rv32is);
    csr_read(csr_pkg::csr_mhartid, data);
    check_word("mhartid", data, hart_id_value);
    csr_read(csr_pkg::csr_addr_e'(12'h7c0), data);
    check_word("unknown csr", data, '0);
    // Write to an unknown address is dropped
    csr_write(csr_pkg::csr_addr_e'(12'h7c0), 32'hffff_ffff, data);
    csr_read(csr_pkg::csr_addr_e'(12'h7c0), data);
    check_word("unknown csr after write", data, '0);
endtask

task automatic config_read_write();
    csr_pkg::csr_addr_e rw_addrs [5];
    csr_pkg::word_t     d1;
    csr_pkg::word_t     d2;
    csr_pkg::word_t     data;
    rw_addrs[0] = csr_pkg::csr_mscratch;
    rw_addrs[1] = csr_pkg::csr_sscratch;
    rw_addrs[2] = csr_pkg::csr_mtvec;
    rw_addrs[3] = csr_pkg::csr_stvec;
    rw_addrs[4] = csr_pkg::csr_medeleg;
    for (int i = 0; i < 5; i++) begin
        d1 = $random(seed);
        d2 = $random(seed);
        csr_write(rw_addrs[i], d1, data);
        csr_read(rw_addrs[i], data);
        check_word(rw_addrs[i].name(), data, d1);
        csr_write(rw_addrs[i], d2, data);
        check_word({rw_addrs[i].name(), " old value"}, data, d1);
        csr_read(rw_addrs[i], data);
        check_word(rw_addrs[i].name(), data, d2);
    end
    // misa is read-only
    csr_write(csr_pkg::csr_misa, 32'hffff_ffff, data);
    check_word("misa old value", data, misa_rv32is);
    csr_read(csr_pkg::csr_misa, data);
    check_word("misa", data, misa_rv32is);
endtask

task automatic sstatus_masking();
    csr_pkg::status_t exp;
    csr_pkg::word_t   data;
    csr_write(csr_pkg::csr_mstatus, '0, data);
    csr_write(csr_pkg::csr_sstatus, 32'hffff_ffff, data);
    exp      = '0;
    exp.sie  = 1'b1;
    exp.spie = 1'b1;
    exp.spp  = 1'b1;
    csr_read(csr_pkg::csr_mstatus, data);
    check_status("mstatus", csr_pkg::status_t'(data), exp);

    csr_write(csr_pkg::csr_mstatus, 32'hffff_ffff, data);
    csr_read(csr_pkg::csr_sstatus, data);
    check_word("sstatus", data, exp);
    exp.mie  = 1'b1;
    exp.mpie = 1'b1;
    exp.mpp  = 2'b11;
    csr_read(csr_pkg::csr_mstatus, data);
    check_status("mstatus", csr_pkg::status_t'(data), exp);
    csr_write(csr_pkg::csr_mstatus, '0, data);
endtask

task automatic machine_trap_mret();
    csr_pkg::status_t exp;
    csr_pkg::cause_t  cause;
    csr_pkg::word_t   cause_word;
    csr_pkg::word_t   pc;
    csr_pkg::word_t   tval;
    csr_pkg::word_t   data;
    csr_pkg::priv_e   priv_before;
    cause.interrupt = 1'b0;
    cause.code      = 4'd2;
    pc   = 32'h0000_1234;
    tval = 32'hdead_beef;
    csr_write(csr_pkg::csr_medeleg, '0, data);
    csr_write(csr_pkg::csr_mtvec, 32'h8000_0103, data);
    exp     = '0;
    exp.mie = 1'b1;
    csr_write(csr_pkg::csr_mstatus, exp, data);
    // Still in machine mode since reset
    priv_before = csr_pkg::priv_machine;

    transfer(csr_pkg::op_trap, csr_pkg::csr_mstatus, '0, cause, pc, tval, data);
    check_word("trap vector", data, 32'h8000_0100);
    csr_read(csr_pkg::csr_mepc, data);
    check_word("mepc", data, pc);
    cause_word       = '0;
    cause_word[31]   = cause.interrupt;
    cause_word[3:0]  = cause.code;
    csr_read(csr_pkg::csr_mcause, data);
    check_word("mcause", data, cause_word);
    csr_read(csr_pkg::csr_mtval, data);
    check_word("mtval", data, tval);
    exp      = '0;
    exp.mpie = 1'b1;
    exp.mpp  = priv_before;
    csr_read(csr_pkg::csr_mstatus, data);
    check_status("mstatus after trap", csr_pkg::status_t'(data), exp);
    check_priv("priv after trap", priv, csr_pkg::priv_machine);

    transfer(csr_pkg::op_mret, csr_pkg::csr_mstatus, '0, '0, '0, '0, data);
    check_word("mret target", data, pc);
    check_priv("priv after mret", priv, priv_before);
    exp.mie = 1'b1;
    exp.mpp = csr_pkg::priv_user;
    csr_read(csr_pkg::csr_mstatus, data);
    check_status("mstatus after mret", csr_pkg::status_t'(data), exp);
endtask

task automatic delegated_trap_sret();
    csr_pkg::status_t exp;
    csr_pkg::cause_t  cause;
    csr_pkg::word_t   pc;
    csr_pkg::word_t   mepc_before;
    csr_pkg::word_t   data;
    cause.interrupt = 1'b0;
    cause.code      = 4'd8;
    pc          = 32'h0000_2000;
    mepc_before = 32'h0000_0c40;
    csr_write(csr_pkg::csr_medeleg, 32'd1 << cause.code, data);
    csr_write(csr_pkg::csr_stvec, 32'h0000_4001, data);
    csr_write(csr_pkg::csr_mepc, mepc_before, data);
    exp     = '0;
    exp.sie = 1'b1;
    csr_write(csr_pkg::csr_mstatus, exp, data);

    transfer(csr_pkg::op_trap, csr_pkg::csr_mstatus, '0, cause, pc, 32'h0, data);
    check_word("trap vector", data, 32'h0000_4000);
    csr_read(csr_pkg::csr_sepc, data);
    check_word("sepc", data, pc);
    csr_read(csr_pkg::csr_scause, data);
    check_word("scause", data, {28'd0, cause.code});
    csr_read(csr_pkg::csr_mepc, data);
    check_word("mepc", data, mepc_before);
    check_priv("priv after trap", priv, csr_pkg::priv_supervisor);
    // Trap taken from machine mode
    exp      = '0;
    exp.spie = 1'b1;
    exp.spp  = 1'b1;
    csr_read(csr_pkg::csr_mstatus, data);
    check_status("mstatus after trap", csr_pkg::status_t'(data), exp);

    transfer(csr_pkg::op_sret, csr_pkg::csr_mstatus, '0, '0, '0, '0, data);
    check_word("sret target", data, pc);
    check_priv("priv after sret", priv, csr_pkg::priv_supervisor);
    exp.sie = 1'b1;
    exp.spp = 1'b0;
    csr_read(csr_pkg::csr_mstatus, data);
    check_status("mstatus after sret", csr_pkg::status_t'(data), exp);
endtask

task automatic cycle_counter();
    csr_pkg::word_t first;
    csr_pkg::word_t second;
    csr_pkg::word_t data;
    csr_read(csr_pkg::csr_cycle, first);
    csr_read(csr_pkg::csr_cycle, second);
    if (second <= first) begin
        value_errors++;
        $display("Fail at %0t: cycle got %h expected more than %h", $time, second, first);
    end
    csr_read(csr_pkg::csr_cycleh, data);
    check_word("cycleh", data, '0);
endtask

/* testbench/tb_csr_unit.sv */
// CSR unit testbench

`timescale 1ns/1ns

module tb_csr_unit;

    localparam int ack_timeout = 20;
    // Ack two cycles after the edge that samples req
    localparam int ack_rise_cycles = 3;
    localparam int ack_fall_cycles = 2;
    localparam csr_pkg::word_t hart_id_value = 32'd5;

    logic               clk;
    logic               rst;
    logic               req;
    csr_pkg::csr_op_e   op;
    csr_pkg::csr_addr_e addr;
    csr_pkg::word_t     wdata;
    csr_pkg::cause_t    trap_cause;
    csr_pkg::word_t     trap_pc;
    csr_pkg::word_t     trap_tval;
    logic               ack;
    csr_pkg::word_t     rdata;
    csr_pkg::priv_e     priv;

    int     value_errors;
    int     handshake_errors;
    integer seed;

    csr_unit #(
        .hart_id (hart_id_value)
    ) i_csr_unit (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .trap_cause (trap_cause),
        .trap_pc    (trap_pc),
        .trap_tval  (trap_tval),
        .ack        (ack),
        .rdata      (rdata),
        .priv       (priv)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_word(input string name, input csr_pkg::word_t got,
                              input csr_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_priv(input string name, input csr_pkg::priv_e got,
                              input csr_pkg::priv_e exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_status(input string name, input csr_pkg::status_t got,
                                input csr_pkg::status_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // One four-phase transfer starting 1 ns after a rising edge
    // ------------------------------------------------------------
    task automatic transfer(input csr_pkg::csr_op_e c_op, input csr_pkg::csr_addr_e c_addr,
                            input csr_pkg::word_t c_wdata, input csr_pkg::cause_t c_cause,
                            input csr_pkg::word_t c_pc, input csr_pkg::word_t c_tval,
                            output csr_pkg::word_t result);
        int edges;
        result = '0;
        edges = 0;
        while (ack && edges < ack_timeout) begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (ack) begin
            handshake_errors++;
            $display("Timeout at %0t: ack stayed high from an earlier transfer", $time);
            return;
        end
        op         = c_op;
        addr       = c_addr;
        wdata      = c_wdata;
        trap_cause = c_cause;
        trap_pc    = c_pc;
        trap_tval  = c_tval;
        req        = 1'b1;
        edges = 0;
        while (!ack && edges < ack_timeout) begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (!ack) begin
            handshake_errors++;
            $display("Timeout at %0t: ack did not rise for a %s request", $time, c_op.name());
            req = 1'b0;
            return;
        end
        if (edges != ack_rise_cycles) begin
            handshake_errors++;
            $display("Handshake error at %0t: ack rose %0d edges after req, not %0d",
                     $time, edges, ack_rise_cycles);
        end
        result = rdata;
        req = 1'b0;
        edges = 0;
        while (ack && edges < ack_timeout) begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (ack) begin
            handshake_errors++;
            $display("Timeout at %0t: ack did not fall after req dropped", $time);
        end else if (edges != ack_fall_cycles) begin
            handshake_errors++;
            $display("Handshake error at %0t: ack fell %0d edges after req, not %0d",
                     $time, edges, ack_fall_cycles);
        end
    endtask

    task automatic csr_read(input csr_pkg::csr_addr_e a, output csr_pkg::word_t data);
        transfer(csr_pkg::op_read, a, '0, '0, '0, '0, data);
    endtask

    task automatic csr_write(input csr_pkg::csr_addr_e a, input csr_pkg::word_t data,
                             output csr_pkg::word_t old);
        transfer(csr_pkg::op_write, a, data, '0, '0, '0, old);
    endtask

    `include "csr_tests.svh"

    initial begin
        value_errors     = 0;
        handshake_errors = 0;
        seed       = 32'h2803_183a;
        rst        = 1'b1;
        req        = 1'b0;
        op         = csr_pkg::op_read;
        addr       = csr_pkg::csr_mstatus;
        wdata      = '0;
        trap_cause = '0;
        trap_pc    = '0;
        trap_tval  = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_values();
        config_read_write();
        sstatus_masking();
        machine_trap_mret();
        delegated_trap_sret();
        cycle_counter();

        $display("Checks done: %0d value errors, %0d handshake errors",
                 value_errors, handshake_errors);
        if (value_errors == 0 && handshake_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* hdl/csr_unit.sv */
// Machine and supervisor CSR unit

`timescale 1ns/1ns

module csr_unit #(
    parameter logic [31:0] hart_id = 32'd0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  csr_pkg::csr_op_e   op,
    input  csr_pkg::csr_addr_e addr,
    input  csr_pkg::word_t     wdata,
    input  csr_pkg::cause_t    trap_cause,
    input  csr_pkg::word_t     trap_pc,
    input  csr_pkg::word_t     trap_tval,
    output logic               ack,
    output csr_pkg::word_t     rdata,
    output csr_pkg::priv_e     priv
);

    csr_pkg::word_t medeleg;
    csr_pkg::word_t mtvec;
    csr_pkg::word_t stvec;

    csr_access_if bus ();

    csr_request_ctrl i_csr_request_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .trap_cause (trap_cause),
        .trap_pc    (trap_pc),
        .trap_tval  (trap_tval),
        .ack        (ack),
        .rdata      (rdata),
        .bus        (bus.ctrl)
    );

    csr_trap_regs i_csr_trap_regs (
        .clk     (clk),
        .rst     (rst),
        .bus     (bus.regs),
        .medeleg (medeleg),
        .mtvec   (mtvec),
        .stvec   (stvec),
        .priv    (priv)
    );

    csr_config_regs #(
        .hart_id (hart_id)
    ) i_csr_config_regs (
        .clk     (clk),
        .rst     (rst),
        .bus     (bus.regs),
        .medeleg (medeleg),
        .mtvec   (mtvec),
        .stvec   (stvec)
    );

endmodule

/* hdl/csr_config_regs.sv */
// Vector, scratch, delegation and counter registers

`timescale 1ns/1ns

module csr_config_regs #(
    parameter logic [31:0] hart_id = 32'd0
) (
    input  logic            clk,
    input  logic            rst,
    csr_access_if.regs      bus,
    output csr_pkg::word_t  medeleg,
    output csr_pkg::word_t  mtvec,
    output csr_pkg::word_t  stvec
);

    csr_pkg::word_t mscratch;
    csr_pkg::word_t sscratch;
    logic [63:0]    cycle;
    logic           wr_en;

    assign wr_en = bus.exec && (bus.op == csr_pkg::op_write);

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= '0;
            stvec    <= '0;
            mscratch <= '0;
            sscratch <= '0;
            medeleg  <= '0;
        end else if (wr_en) begin
            case (bus.addr)
                csr_pkg::csr_mtvec:    mtvec    <= bus.wdata;
                csr_pkg::csr_stvec:    stvec    <= bus.wdata;
                csr_pkg::csr_mscratch: mscratch <= bus.wdata;
                csr_pkg::csr_sscratch: sscratch <= bus.wdata;
                csr_pkg::csr_medeleg:  medeleg  <= bus.wdata;
                default: begin
                end
            endcase
        end
    end

    // Free running cycle counter
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    // ------------------------------------------------------------
    // Read data
    // ------------------------------------------------------------
    always_comb begin
        bus.config_rdata = '0;
        if (bus.op == csr_pkg::op_read || bus.op == csr_pkg::op_write) begin
            case (bus.addr)
                csr_pkg::csr_mtvec:     bus.config_rdata = mtvec;
                csr_pkg::csr_stvec:     bus.config_rdata = stvec;
                csr_pkg::csr_mscratch:  bus.config_rdata = mscratch;
                csr_pkg::csr_sscratch:  bus.config_rdata = sscratch;
                csr_pkg::csr_medeleg:   bus.config_rdata = medeleg;
                csr_pkg::csr_cycle:     bus.config_rdata = cycle[31:0];
                csr_pkg::csr_cycleh:    bus.config_rdata = cycle[63:32];
                csr_pkg::csr_misa:      bus.config_rdata = csr_pkg::misa_value;
                // Identity registers not implemented
                csr_pkg::csr_mvendorid: bus.config_rdata = '0;
                csr_pkg::csr_marchid:   bus.config_rdata = '0;
                csr_pkg::csr_mimpid:    bus.config_rdata = '0;
                csr_pkg::csr_mhartid:   bus.config_rdata = hart_id;
                default:                bus.config_rdata = '0;
            endcase
        end
    end

endmodule

/* hdl/csr_trap_regs.sv */
// Privilege, status and trap record registers

`timescale 1ns/1ns

module csr_trap_regs (
    input  logic            clk,
    input  logic            rst,
    csr_access_if.regs      bus,
    input  csr_pkg::word_t  medeleg,
    input  csr_pkg::word_t  mtvec,
    input  csr_pkg::word_t  stvec,
    output csr_pkg::priv_e  priv
);

    csr_pkg::status_t status;
    csr_pkg::word_t   mepc;
    csr_pkg::cause_t  mcause;
    csr_pkg::word_t   mtval;
    csr_pkg::word_t   sepc;
    csr_pkg::cause_t  scause;
    csr_pkg::word_t   stval;

    csr_pkg::priv_e   next_priv;
    csr_pkg::status_t next_status;
    logic             delegate;

    function automatic csr_pkg::word_t cause_word(csr_pkg::cause_t c);
        return {c.interrupt, 27'd0, c.code};
    endfunction

    assign delegate = medeleg[{1'b0, bus.cause.code}];

    // ------------------------------------------------------------
    // Next privilege and status
    // ------------------------------------------------------------
    always_comb begin
        next_priv   = priv;
        next_status = status;
        if (bus.exec) begin
            case (bus.op)
                csr_pkg::op_trap: begin
                    if (delegate) begin
                        next_priv        = csr_pkg::priv_supervisor;
                        next_status.spie = status.sie;
                        next_status.sie  = 1'b0;
                        next_status.spp  = priv[0];
                    end else begin
                        next_priv        = csr_pkg::priv_machine;
                        next_status.mpie = status.mie;
                        next_status.mie  = 1'b0;
                        next_status.mpp  = priv;
                    end
                end
                csr_pkg::op_mret: begin
                    next_priv       = csr_pkg::priv_e'(status.mpp);
                    next_status.mie = status.mpie;
                    next_status.mpp = csr_pkg::priv_user;
                end
                csr_pkg::op_sret: begin
                    next_priv       = status.spp ? csr_pkg::priv_supervisor
                                                 : csr_pkg::priv_user;
                    next_status.sie = status.spie;
                    next_status.spp = 1'b0;
                end
                csr_pkg::op_write: begin
                    if (bus.addr == csr_pkg::csr_mstatus) begin
                        next_status = csr_pkg::status_t'(bus.wdata & csr_pkg::mstatus_mask);
                    end else if (bus.addr == csr_pkg::csr_sstatus) begin
                        next_status = csr_pkg::status_t'((status & ~csr_pkg::sstatus_mask)
                                    | (bus.wdata & csr_pkg::sstatus_mask));
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv   <= csr_pkg::priv_machine;
            status <= '0;
        end else begin
            priv   <= next_priv;
            status <= next_status;
        end
    end

    // Trap records
    always_ff @(posedge clk) begin
        if (bus.exec) begin
            case (bus.op)
                csr_pkg::op_trap: begin
                    if (delegate) begin
                        sepc   <= bus.pc;
                        scause <= bus.cause;
                        stval  <= bus.tval;
                    end else begin
                        mepc   <= bus.pc;
                        mcause <= bus.cause;
                        mtval  <= bus.tval;
                    end
                end
                csr_pkg::op_write: begin
                    case (bus.addr)
                        csr_pkg::csr_mepc:   mepc   <= bus.wdata;
                        csr_pkg::csr_mcause: mcause <= {bus.wdata[31], bus.wdata[3:0]};
                        csr_pkg::csr_mtval:  mtval  <= bus.wdata;
                        csr_pkg::csr_sepc:   sepc   <= bus.wdata;
                        csr_pkg::csr_scause: scause <= {bus.wdata[31], bus.wdata[3:0]};
                        csr_pkg::csr_stval:  stval  <= bus.wdata;
                        default: begin
                        end
                    endcase
                end
                default: begin
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Read data from pre-update values
    // ------------------------------------------------------------
    always_comb begin
        bus.trap_rdata = '0;
        case (bus.op)
            csr_pkg::op_read, csr_pkg::op_write: begin
                case (bus.addr)
                    csr_pkg::csr_mstatus: bus.trap_rdata = status;
                    csr_pkg::csr_sstatus: bus.trap_rdata = status & csr_pkg::sstatus_mask;
                    csr_pkg::csr_mepc:    bus.trap_rdata = mepc;
                    csr_pkg::csr_mcause:  bus.trap_rdata = cause_word(mcause);
                    csr_pkg::csr_mtval:   bus.trap_rdata = mtval;
                    csr_pkg::csr_sepc:    bus.trap_rdata = sepc;
                    csr_pkg::csr_scause:  bus.trap_rdata = cause_word(scause);
                    csr_pkg::csr_stval:   bus.trap_rdata = stval;
                    default:              bus.trap_rdata = '0;
                endcase
            end
            // Target vector with mode bits cleared
            csr_pkg::op_trap: begin
                bus.trap_rdata = delegate ? {stvec[31:2], 2'b00} : {mtvec[31:2], 2'b00};
            end
            csr_pkg::op_mret: bus.trap_rdata = mepc;
            csr_pkg::op_sret: bus.trap_rdata = sepc;
            default:          bus.trap_rdata = '0;
        endcase
    end

endmodule

/* hdl/csr_request_ctrl.sv */
// CSR request handshake controller

`timescale 1ns/1ns

module csr_request_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  csr_pkg::csr_op_e   op,
    input  csr_pkg::csr_addr_e addr,
    input  csr_pkg::word_t     wdata,
    input  csr_pkg::cause_t    trap_cause,
    input  csr_pkg::word_t     trap_pc,
    input  csr_pkg::word_t     trap_tval,
    output logic               ack,
    output csr_pkg::word_t     rdata,
    csr_access_if.ctrl         bus
);

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_hold
    } state_e;

    state_e state;
    logic   req_q;

    // ------------------------------------------------------------
    // Handshake FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b0;
            state <= st_idle;
        end else begin
            req_q <= req;
            case (state)
                st_idle: begin
                    if (req_q) begin
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    state <= st_hold;
                end
                st_hold: begin
                    // Stay here until the requester drops req
                    if (!req_q) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign bus.exec = (state == st_exec);
    assign ack      = (state == st_hold);

    // Command capture
    always_ff @(posedge clk) begin
        if (state == st_idle && req_q) begin
            bus.op    <= op;
            bus.addr  <= addr;
            bus.wdata <= wdata;
            bus.cause <= trap_cause;
            bus.pc    <= trap_pc;
            bus.tval  <= trap_tval;
        end
    end

    // Response held for the rest of the transfer
    always_ff @(posedge clk) begin
        if (state == st_exec) begin
            rdata <= bus.trap_rdata | bus.config_rdata;
        end
    end

endmodule

/* hdl/csr_access_if.sv */
// CSR command bus

`timescale 1ns/1ns

interface csr_access_if;

    logic               exec;
    csr_pkg::csr_op_e   op;
    csr_pkg::csr_addr_e addr;
    csr_pkg::word_t     wdata;
    csr_pkg::cause_t    cause;
    csr_pkg::word_t     pc;
    csr_pkg::word_t     tval;

    // Each block returns zero for what it does not own
    csr_pkg::word_t     trap_rdata;
    csr_pkg::word_t     config_rdata;

    modport ctrl (
        output exec, op, addr, wdata, cause, pc, tval,
        input  trap_rdata, config_rdata
    );

    modport regs (
        input  exec, op, addr, wdata, cause, pc, tval,
        output trap_rdata, config_rdata
    );

endinterface

/* hdl/csr_pkg.sv */
// CSR unit shared types and constants

package csr_pkg;

    typedef logic [31:0] word_t;

    // ------------------------------------------------------------
    // Privilege levels and command opcodes
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        priv_user       = 2'd0,
        priv_supervisor = 2'd1,
        priv_machine    = 2'd3
    } priv_e;

    typedef enum logic [2:0] {
        op_read  = 3'd0,
        op_write = 3'd1,
        op_trap  = 3'd2,
        op_mret  = 3'd3,
        op_sret  = 3'd4
    } csr_op_e;

    // Standard CSR addresses
    typedef enum logic [11:0] {
        csr_sstatus   = 12'h100,
        csr_stvec     = 12'h105,
        csr_sscratch  = 12'h140,
        csr_sepc      = 12'h141,
        csr_scause    = 12'h142,
        csr_stval     = 12'h143,
        csr_mstatus   = 12'h300,
        csr_misa      = 12'h301,
        csr_medeleg   = 12'h302,
        csr_mtvec     = 12'h305,
        csr_mscratch  = 12'h340,
        csr_mepc      = 12'h341,
        csr_mcause    = 12'h342,
        csr_mtval     = 12'h343,
        csr_cycle     = 12'hc00,
        csr_cycleh    = 12'hc80,
        csr_mvendorid = 12'hf11,
        csr_marchid   = 12'hf12,
        csr_mimpid    = 12'hf13,
        csr_mhartid   = 12'hf14
    } csr_addr_e;

    // ------------------------------------------------------------
    // Status and cause layout
    // ------------------------------------------------------------
    typedef struct packed {
        logic [18:0] wpri_hi;
        logic [1:0]  mpp;
        logic [1:0]  wpri_9;
        logic        spp;
        logic        mpie;
        logic        wpri_6;
        logic        spie;
        logic        wpri_4;
        logic        mie;
        logic        wpri_2;
        logic        sie;
        logic        wpri_0;
    } status_t;

    typedef struct packed {
        logic       interrupt;
        logic [3:0] code;
    } cause_t;

    // Implemented mstatus bits
    localparam word_t mstatus_mask = 32'h0000_19aa;
    // SIE, SPIE and SPP
    localparam word_t sstatus_mask = 32'h0000_0122;
    // MXL=1, I and S
    localparam word_t misa_value   = 32'h4004_0100;

endpackage
